//--- common/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    typedef logic [63:0] xlenWord_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_IMM32  = 7'b0011011,
        OP_OP     = 7'b0110011,
        OP_OP32   = 7'b0111011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branchFunct_e;

    localparam funct3_t F3_ADD  = 3'b000;  // add, sub
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;  // srl, sra
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct3_t F3_MUL  = 3'b000;  // div/rem have funct3[2] set

    localparam funct7_t F7_BASE   = 7'b0000000;
    localparam funct7_t F7_ALT    = 7'b0100000;  // sub, sra
    localparam funct7_t F7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

//--- common/rvMemPkg.sv
`default_nettype none

package rvMemPkg;

    // one bit per byte lane of a doubleword
    typedef logic [7:0] byteMask_t;

    typedef logic [63:0] memAddr_t;

    // same encoding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'b00,
        SIZE_HALF   = 2'b01,
        SIZE_WORD   = 2'b10,
        SIZE_DOUBLE = 2'b11
    } accessSize_e;

endpackage

`default_nettype wire

//--- decode/immDecode.sv
`default_nettype none
`timescale 1ns/100ps

module immDecode (
    input  rvIsaPkg::inst_t     inst,
    output rvIsaPkg::xlenWord_t immI,
    output rvIsaPkg::xlenWord_t immS,
    output rvIsaPkg::xlenWord_t immB,
    output rvIsaPkg::xlenWord_t immU,
    output rvIsaPkg::xlenWord_t immJ,
    output rvIsaPkg::regAddr_t  rd,
    output rvIsaPkg::regAddr_t  rs1Addr,
    output rvIsaPkg::regAddr_t  rs2Addr,
    output rvIsaPkg::funct3_t   funct3,
    output rvIsaPkg::funct7_t   funct7
);
    import rvIsaPkg::*;

    xlenWord_t signFill;

    assign signFill = {64{inst[31]}};  // every format signs from bit 31

    assign immI = {signFill[63:12], inst[31:20]};
    assign immS = {signFill[63:12], inst[31:25], inst[11:7]};
    assign immB = {signFill[63:13], inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {signFill[63:32], inst[31:12], 12'b0};
    assign immJ = {signFill[63:21], inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign rd      = inst[11:7];
    assign rs1Addr = inst[19:15];
    assign rs2Addr = inst[24:20];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];

endmodule

`default_nettype wire

//--- execute/execUnit.sv
`default_nettype none
`timescale 1ns/100ps

module execUnit (
    input  logic                instValid,
    input  rvIsaPkg::inst_t     inst,
    input  rvIsaPkg::xlenWord_t pc,
    input  rvIsaPkg::xlenWord_t rs1,
    input  rvIsaPkg::xlenWord_t rs2,
    input  rvIsaPkg::xlenWord_t immI,
    input  rvIsaPkg::xlenWord_t immS,
    input  rvIsaPkg::xlenWord_t immU,
    input  rvIsaPkg::funct3_t   funct3,
    input  rvIsaPkg::funct7_t   funct7,
    input  rvIsaPkg::xlenWord_t loadWord,
    output logic                wen,
    output rvIsaPkg::xlenWord_t wdata,
    output logic                memWen,
    output rvMemPkg::memAddr_t  memAddr,
    output rvMemPkg::byteMask_t memMask,
    output rvIsaPkg::xlenWord_t memData
);
    import rvIsaPkg::*;
    import rvMemPkg::*;

    opcode_e     opcode;
    accessSize_e size;
    logic        regForm;
    logic        isWord;
    logic        mulDiv;
    logic        extSigned;
    logic        rLegal;
    logic        shiftImmOk;
    logic        divZero;
    logic        divOvf;
    logic        aligned;
    logic        legal;
    logic [5:0]  shamt;
    xlenWord_t   rawB;
    xlenWord_t   opA;
    xlenWord_t   opB;
    xlenWord_t   aluRes;
    xlenWord_t   mdRes;
    xlenWord_t   opRes;
    xlenWord_t   laneWord;
    xlenWord_t   loadRes;
    xlenWord_t   pcPlus4;
    memAddr_t    effAddr;

    function automatic xlenWord_t sext32(input logic [31:0] value);
        return {{32{value[31]}}, value};
    endfunction

    assign opcode     = opcode_e'(inst[6:0]);
    assign size       = accessSize_e'(funct3[1:0]);
    assign regForm    = (opcode == OP_OP) || (opcode == OP_OP32);
    assign isWord     = (opcode == OP_IMM32) || (opcode == OP_OP32);
    assign mulDiv     = regForm && (funct7 == F7_MULDIV);
    assign rLegal     = (funct7 == F7_BASE) ||
                        (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
    assign shiftImmOk = (inst[31:26] == 6'b000000) ||
                        (inst[31:26] == 6'b010000 && funct3 == F3_SR);
    assign pcPlus4    = pc + 64'd4;

    // W forms work on extended low halves, result re-signed from bit 31
    assign extSigned = mulDiv ? !funct3[0] : funct7[5];
    assign rawB      = regForm ? rs2 : immI;
    assign opA = !isWord ? rs1 : (extSigned ? sext32(rs1[31:0]) : {32'b0, rs1[31:0]});
    assign opB = !isWord ? rawB : (extSigned ? sext32(rawB[31:0]) : {32'b0, rawB[31:0]});
    assign shamt = isWord ? {1'b0, opB[4:0]} : opB[5:0];

    always_comb begin
        case (funct3)
            F3_ADD:  aluRes = (regForm && funct7[5]) ? opA - opB : opA + opB;
            F3_SLL:  aluRes = opA << shamt;
            F3_SLT:  aluRes = {63'b0, $signed(opA) < $signed(opB)};
            F3_SLTU: aluRes = {63'b0, opA < opB};
            F3_XOR:  aluRes = opA ^ opB;
            F3_SR: begin
                if (funct7[5]) begin
                    aluRes = $signed(opA) >>> shamt;
                end else begin
                    aluRes = opA >> shamt;
                end
            end
            F3_OR:   aluRes = opA | opB;
            default: aluRes = opA & opB;
        endcase
    end

    assign divZero = (opB == '0);
    assign divOvf  = !funct3[0] && (opA == {1'b1, 63'b0}) && (opB == '1);

    // funct3[1] selects rem, funct3[0] unsigned
    always_comb begin
        mdRes = opA * opB;
        if (funct3[2]) begin
            if (divZero) begin
                mdRes = funct3[1] ? opA : '1;
            end else if (divOvf) begin
                mdRes = funct3[1] ? '0 : opA;
            end else if (funct3[0]) begin
                mdRes = funct3[1] ? opA % opB : opA / opB;
            end else begin
                mdRes = funct3[1] ? $signed(opA) % $signed(opB) : $signed(opA) / $signed(opB);
            end
        end
    end

    assign opRes = mulDiv ? mdRes : aluRes;

    // loads and stores share the lane and size logic
    assign effAddr  = rs1 + ((opcode == OP_STORE) ? immS : immI);
    assign laneWord = loadWord >> {effAddr[2:0], 3'b000};

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                memMask = 8'h01;
                loadRes = {{56{laneWord[7] & ~funct3[2]}}, laneWord[7:0]};
            end
            SIZE_HALF: begin
                memMask = 8'h03;
                loadRes = {{48{laneWord[15] & ~funct3[2]}}, laneWord[15:0]};
            end
            SIZE_WORD: begin
                memMask = 8'h0f;
                loadRes = {{32{laneWord[31] & ~funct3[2]}}, laneWord[31:0]};
            end
            default: begin
                memMask = 8'hff;
                loadRes = laneWord;
            end
        endcase
    end

    assign memWen  = instValid && (opcode == OP_STORE) && !funct3[2];
    assign memAddr = effAddr;
    assign memData = rs2;
    assign aligned = (effAddr[2:0] & {memMask[7], memMask[3], memMask[1]}) == 3'b000;

    always_comb begin
        legal = 1'b1;
        case (opcode)
            OP_LUI:   wdata = immU;
            OP_AUIPC: wdata = pc + immU;
            OP_JAL:   wdata = pcPlus4;
            OP_JALR: begin
                wdata = pcPlus4;
                legal = (funct3 == 3'b000);
            end
            OP_LOAD: begin
                wdata = loadRes;
                legal = (funct3 != 3'b111);  // no ldu
            end
            OP_IMM: begin
                wdata = opRes;
                legal = !(funct3 == F3_SLL || funct3 == F3_SR) || shiftImmOk;
            end
            OP_IMM32: begin
                wdata = sext32(opRes[31:0]);
                legal = (funct3 == F3_ADD) || ((funct3 == F3_SLL || funct3 == F3_SR) && rLegal);
            end
            OP_OP: begin
                wdata = opRes;
                legal = mulDiv ? (funct3 == F3_MUL || funct3[2]) : rLegal;
            end
            OP_OP32: begin
                wdata = sext32(opRes[31:0]);
                legal = mulDiv ? (funct3 == F3_MUL || funct3[2])
                               : rLegal && (funct3 == F3_ADD || funct3 == F3_SLL ||
                                            funct3 == F3_SR);
            end
            default: begin
                wdata = '0;  // stores, branches and unknown encodings
                legal = 1'b0;
            end
        endcase
    end

    assign wen = instValid && legal;

    always_comb begin
        if (instValid && (opcode == OP_LOAD || opcode == OP_STORE)) begin
            assert #0 (aligned)
            else $error("misaligned memory access at 0x%h", effAddr);
        end
    end

endmodule

`default_nettype wire

//--- execute/nextPcUnit.sv
`default_nettype none
`timescale 1ns/100ps

module nextPcUnit #(
    parameter rvIsaPkg::xlenWord_t RESET_PC = 64'h8000_0000
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                instValid,
    input  rvIsaPkg::inst_t     inst,
    input  rvIsaPkg::xlenWord_t rs1,
    input  rvIsaPkg::xlenWord_t rs2,
    input  rvIsaPkg::xlenWord_t immB,
    input  rvIsaPkg::xlenWord_t immJ,
    input  rvIsaPkg::xlenWord_t immI,
    input  rvIsaPkg::funct3_t   funct3,
    output rvIsaPkg::xlenWord_t pc
);
    import rvIsaPkg::*;

    opcode_e      opcode;
    branchFunct_e branchOp;
    logic         taken;
    xlenWord_t    pcPlus4;
    xlenWord_t    nextPc;

    assign opcode   = opcode_e'(inst[6:0]);
    assign branchOp = branchFunct_e'(funct3);
    assign pcPlus4  = pc + 64'd4;

    always_comb begin
        case (branchOp)
            BR_BEQ:  taken = (rs1 == rs2);
            BR_BNE:  taken = (rs1 != rs2);
            BR_BLT:  taken = $signed(rs1) < $signed(rs2);
            BR_BGE:  taken = $signed(rs1) >= $signed(rs2);
            BR_BLTU: taken = rs1 < rs2;
            BR_BGEU: taken = rs1 >= rs2;
            default: taken = 1'b0;  // 010/011 undefined, falls through
        endcase
    end

    always_comb begin
        case (opcode)
            OP_BRANCH: nextPc = taken ? pc + immB : pcPlus4;
            OP_JAL:    nextPc = pc + immJ;
            OP_JALR:   nextPc = (funct3 == 3'b000) ? ((rs1 + immI) & ~64'd1) : pcPlus4;
            default:   nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (instValid) begin
            pc <= nextPc;
        end
    end

    // no compressed ISA, so targets must stay word aligned
    assert property (@(posedge clk) disable iff (reset) instValid |=> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- logic/regFile.sv
`default_nettype none
`timescale 1ns/100ps

module regFile (
    input  logic                clk,
    input  logic                reset,
    input  logic                wen,
    input  rvIsaPkg::regAddr_t  rd,
    input  rvIsaPkg::regAddr_t  rs1Addr,
    input  rvIsaPkg::regAddr_t  rs2Addr,
    input  rvIsaPkg::xlenWord_t wdata,
    output rvIsaPkg::xlenWord_t rs1,
    output rvIsaPkg::xlenWord_t rs2
);
    import rvIsaPkg::*;

    xlenWord_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd != 5'd0) begin  // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    assign rs1 = regs[rs1Addr];
    assign rs2 = regs[rs2Addr];

endmodule

`default_nettype wire

//--- logic/dataMemory.sv
`default_nettype none
`timescale 1ns/100ps

module dataMemory #(
    parameter int unsigned        MEM_WORDS = 256,
    parameter rvMemPkg::memAddr_t MEM_BASE  = 64'h8000_0000
) (
    input  logic                clk,
    input  logic                memWen,
    input  rvMemPkg::memAddr_t  memAddr,
    input  rvMemPkg::byteMask_t memMask,
    input  rvIsaPkg::xlenWord_t memData,
    output rvIsaPkg::xlenWord_t loadWord
);
    import rvIsaPkg::*;
    import rvMemPkg::*;

    localparam int IDX_BITS = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    xlenWord_t           mem [MEM_WORDS];
    memAddr_t            offset;
    logic [IDX_BITS-1:0] wordIdx;
    logic [2:0]          lane;
    byteMask_t           laneMask;
    xlenWord_t           laneData;

    assign offset   = memAddr - MEM_BASE;
    assign wordIdx  = offset[IDX_BITS+2:3];
    assign lane     = memAddr[2:0];
    assign laneMask = memMask << lane;
    assign laneData = memData << {lane, 3'b000};  // move to the addressed lane

    assign loadWord = mem[wordIdx];

    always_ff @(posedge clk) begin
        if (memWen) begin
            for (int b = 0; b < 8; b++) begin
                if (laneMask[b]) begin
                    mem[wordIdx][b*8 +: 8] <= laneData[b*8 +: 8];
                end
            end
        end
    end

    // wraps below MEM_BASE, so one compare covers both ends
    assert property (@(posedge clk) memWen |-> offset < (memAddr_t'(MEM_WORDS) << 3));

endmodule

`default_nettype wire

//--- logic/rvCore.sv
`default_nettype none
`timescale 1ns/100ps

module rvCore #(
    parameter rvIsaPkg::xlenWord_t RESET_PC  = 64'h8000_0000,
    parameter int unsigned         MEM_WORDS = 256,
    parameter rvMemPkg::memAddr_t  MEM_BASE  = 64'h8000_0000
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                instValid,
    input  rvIsaPkg::inst_t     inst,
    output rvIsaPkg::xlenWord_t pc,
    output logic                commitWen,
    output rvIsaPkg::regAddr_t  commitAddr,
    output rvIsaPkg::xlenWord_t commitData
);
    import rvIsaPkg::*;
    import rvMemPkg::*;

    xlenWord_t immI;
    xlenWord_t immS;
    xlenWord_t immB;
    xlenWord_t immU;
    xlenWord_t immJ;
    regAddr_t  rs1Addr;
    regAddr_t  rs2Addr;
    funct3_t   funct3;
    funct7_t   funct7;
    xlenWord_t rs1;
    xlenWord_t rs2;
    xlenWord_t loadWord;
    logic      memWen;
    memAddr_t  memAddr;
    byteMask_t memMask;
    xlenWord_t memData;

    immDecode decode (
        .inst    (inst),
        .immI    (immI),
        .immS    (immS),
        .immB    (immB),
        .immU    (immU),
        .immJ    (immJ),
        .rd      (commitAddr),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .funct3  (funct3),
        .funct7  (funct7)
    );

    execUnit execute (
        .instValid (instValid),
        .inst      (inst),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .immI      (immI),
        .immS      (immS),
        .immU      (immU),
        .funct3    (funct3),
        .funct7    (funct7),
        .loadWord  (loadWord),
        .wen       (commitWen),
        .wdata     (commitData),
        .memWen    (memWen),
        .memAddr   (memAddr),
        .memMask   (memMask),
        .memData   (memData)
    );

    nextPcUnit #(
        .RESET_PC (RESET_PC)
    ) nextPc (
        .clk       (clk),
        .reset     (reset),
        .instValid (instValid),
        .inst      (inst),
        .rs1       (rs1),
        .rs2       (rs2),
        .immB      (immB),
        .immJ      (immJ),
        .immI      (immI),
        .funct3    (funct3),
        .pc        (pc)
    );

    regFile regs (
        .clk     (clk),
        .reset   (reset),
        .wen     (commitWen),  // retire write doubles as the trace
        .rd      (commitAddr),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .wdata   (commitData),
        .rs1     (rs1),
        .rs2     (rs2)
    );

    dataMemory #(
        .MEM_WORDS (MEM_WORDS),
        .MEM_BASE  (MEM_BASE)
    ) dmem (
        .clk      (clk),
        .memWen   (memWen),
        .memAddr  (memAddr),
        .memMask  (memMask),
        .memData  (memData),
        .loadWord (loadWord)
    );

endmodule

`default_nettype wire

//--- testbench/rvCoreTb.sv
`default_nettype none
`timescale 1ns/100ps

module rvCoreTb;
    import rvIsaPkg::*;

    localparam xlenWord_t RESET_PC  = 64'h8000_0000;
    localparam xlenWord_t MEM_BASE  = 64'h8000_0000;
    localparam xlenWord_t DATA_ADDR = 64'h8000_0100;

    logic      clk;
    logic      reset;
    logic      instValid;
    inst_t     inst;
    xlenWord_t pc;
    logic      commitWen;
    regAddr_t  commitAddr;
    xlenWord_t commitData;

    xlenWord_t   regModel [32];
    logic [7:0]  memModel [8];  // the one doubleword at DATA_ADDR
    xlenWord_t   pcModel;
    logic [15:0] lfsrState;

    rvCore #(
        .RESET_PC  (RESET_PC),
        .MEM_WORDS (256),
        .MEM_BASE  (MEM_BASE)
    ) UUT (
        .clk        (clk),
        .reset      (reset),
        .instValid  (instValid),
        .inst       (inst),
        .pc         (pc),
        .commitWen  (commitWen),
        .commitAddr (commitAddr),
        .commitData (commitData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // taps 16,14,13,11
    function automatic logic [63:0] randBits(input int count);
        logic [63:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < count; i++) begin
            fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
            value = {value[62:0], fb};
        end
        return value;
    endfunction

    function automatic xlenWord_t wordExt(input logic [31:0] value);
        return {{32{value[31]}}, value};
    endfunction

    function automatic inst_t rType(input funct7_t f7, input regAddr_t r2, input regAddr_t r1,
                                    input funct3_t f3, input regAddr_t rdst, input logic [6:0] op);
        return {f7, r2, r1, f3, rdst, op};
    endfunction

    function automatic inst_t iType(input logic [11:0] imm, input regAddr_t r1, input funct3_t f3,
                                    input regAddr_t rdst, input logic [6:0] op);
        return {imm, r1, f3, rdst, op};
    endfunction

    function automatic inst_t sType(input logic [11:0] imm, input regAddr_t r2, input regAddr_t r1,
                                    input funct3_t f3);
        return {imm[11:5], r2, r1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic inst_t bType(input logic [12:0] off, input regAddr_t r2, input regAddr_t r1,
                                    input funct3_t f3);
        return {off[12], off[10:5], r2, r1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic inst_t uType(input logic [19:0] imm, input regAddr_t rdst,
                                    input logic [6:0] op);
        return {imm, rdst, op};
    endfunction

    function automatic inst_t jType(input logic [20:0] off, input regAddr_t rdst);
        return {off[20], off[10:1], off[11], off[19:12], rdst, OP_JAL};
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] expected);
        if (got !== expected) begin
            $display("error %s expected 0x%h got 0x%h", name, expected, got);
            $display("Test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // called 10 ns after an edge, returns 10 ns after the next one
    task automatic retire(input inst_t instr, input logic expWen, input xlenWord_t expData,
                          input xlenWord_t expPc);
        inst = instr;
        instValid = 1'b1;
        #40;
        check("commitWen", 64'(commitWen), 64'(expWen));
        if (expWen) begin
            check("commitAddr", 64'(commitAddr), 64'(instr[11:7]));
            check("commitData", commitData, expData);
        end
        @(posedge clk);
        #10;
        instValid = 1'b0;
        inst = '0;
        check("pc", pc, expPc);
        if (expWen && instr[11:7] != 5'd0) begin
            regModel[instr[11:7]] = expData;
        end
        pcModel = expPc;
    endtask

    task automatic writeOp(input inst_t instr, input xlenWord_t expData);
        retire(instr, 1'b1, expData, pcModel + 64'd4);
    endtask

    task automatic regOp(input funct7_t f7, input funct3_t f3, input opcode_e op,
                         input xlenWord_t expData);
        writeOp(rType(f7, 5'd2, 5'd1, f3, 5'd10, op), expData);
    endtask

    task automatic immOp(input logic [11:0] imm, input funct3_t f3, input opcode_e op,
                         input xlenWord_t expData);
        writeOp(iType(imm, 5'd1, f3, 5'd10, op), expData);
    endtask

    task automatic mdOp(input funct3_t f3, input opcode_e op, input regAddr_t r1,
                        input regAddr_t r2, input xlenWord_t expData);
        writeOp(rType(F7_MULDIV, r2, r1, f3, 5'd10, op), expData);
    endtask

    // 9 bits first, then five rounds of slli 11 and addi
    task automatic loadConst(input regAddr_t rdst, input xlenWord_t value);
        writeOp(iType(12'(value[63:55]), 5'd0, F3_ADD, rdst, OP_IMM), 64'(value[63:55]));
        for (int k = 4; k >= 0; k--) begin
            writeOp(iType(12'd11, rdst, F3_SLL, rdst, OP_IMM), regModel[rdst] << 11);
            writeOp(iType({1'b0, value[k*11 +: 11]}, rdst, F3_ADD, rdst, OP_IMM),
                    regModel[rdst] + 64'(value[k*11 +: 11]));
        end
    endtask

    task automatic waitForResetPc();
        int cycles;
        cycles = 0;
        while (pc !== RESET_PC) begin
            if (cycles == 8) begin
                $display("timeout waiting for pc to reach its reset value");
                $display("Test failed");
                $fatal(1, "reset wait expired");
            end else begin
                @(posedge clk);
                #10;
                cycles++;
            end
        end
    endtask

    task automatic idleCycles();
        inst = iType(12'd1, 5'd0, F3_ADD, 5'd1, OP_IMM);  // valid encoding, held off
        check("pc", pc, RESET_PC);
        repeat (5) begin
            #40;
            check("commitWen", 64'(commitWen), 64'd0);
            @(posedge clk);
            #10;
            check("pc", pc, pcModel);
        end
        inst = '0;
    endtask

    task automatic integerOps();
        xlenWord_t   a;
        xlenWord_t   b;
        xlenWord_t   immv;
        logic [11:0] imm;
        logic [5:0]  sh;
        logic [19:0] uimm;
        a = randBits(64);
        b = randBits(64);
        imm = 12'(randBits(12));
        sh = 6'(randBits(6));
        uimm = 20'(randBits(20));
        immv = {{52{imm[11]}}, imm};
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        regOp(F7_BASE, F3_ADD, OP_OP, a + b);
        regOp(F7_ALT, F3_ADD, OP_OP, a - b);
        regOp(F7_BASE, F3_SLL, OP_OP, a << b[5:0]);
        regOp(F7_BASE, F3_SLT, OP_OP, {63'b0, $signed(a) < $signed(b)});
        regOp(F7_BASE, F3_SLTU, OP_OP, {63'b0, a < b});
        regOp(F7_BASE, F3_XOR, OP_OP, a ^ b);
        regOp(F7_BASE, F3_SR, OP_OP, a >> b[5:0]);
        regOp(F7_ALT, F3_SR, OP_OP, $signed(a) >>> b[5:0]);
        regOp(F7_BASE, F3_OR, OP_OP, a | b);
        regOp(F7_BASE, F3_AND, OP_OP, a & b);
        immOp(imm, F3_ADD, OP_IMM, a + immv);
        immOp(imm, F3_SLT, OP_IMM, {63'b0, $signed(a) < $signed(immv)});
        immOp(imm, F3_SLTU, OP_IMM, {63'b0, a < immv});
        immOp(imm, F3_XOR, OP_IMM, a ^ immv);
        immOp(imm, F3_OR, OP_IMM, a | immv);
        immOp(imm, F3_AND, OP_IMM, a & immv);
        immOp({6'b000000, sh}, F3_SLL, OP_IMM, a << sh);
        immOp({6'b000000, sh}, F3_SR, OP_IMM, a >> sh);
        immOp({6'b010000, sh}, F3_SR, OP_IMM, $signed(a) >>> sh);
        regOp(F7_BASE, F3_ADD, OP_OP32, wordExt(a[31:0] + b[31:0]));
        regOp(F7_ALT, F3_ADD, OP_OP32, wordExt(a[31:0] - b[31:0]));
        regOp(F7_BASE, F3_SLL, OP_OP32, wordExt(a[31:0] << b[4:0]));
        regOp(F7_BASE, F3_SR, OP_OP32, wordExt(a[31:0] >> b[4:0]));
        regOp(F7_ALT, F3_SR, OP_OP32, wordExt($signed(a[31:0]) >>> b[4:0]));
        immOp(imm, F3_ADD, OP_IMM32, wordExt(a[31:0] + immv[31:0]));
        immOp({7'b0000000, sh[4:0]}, F3_SLL, OP_IMM32, wordExt(a[31:0] << sh[4:0]));
        immOp({7'b0000000, sh[4:0]}, F3_SR, OP_IMM32, wordExt(a[31:0] >> sh[4:0]));
        immOp({7'b0100000, sh[4:0]}, F3_SR, OP_IMM32, wordExt($signed(a[31:0]) >>> sh[4:0]));
        writeOp(uType(uimm, 5'd11, OP_LUI), {{32{uimm[19]}}, uimm, 12'b0});
        writeOp(uType(uimm, 5'd12, OP_AUIPC), pcModel + {{32{uimm[19]}}, uimm, 12'b0});
        writeOp(iType(12'd5, 5'd1, F3_ADD, 5'd0, OP_IMM), a + 64'd5);  // x0 write is traced
        writeOp(rType(F7_BASE, 5'd2, 5'd0, F3_ADD, 5'd13, OP_OP), b);
        retire(32'h0000_000f, 1'b0, '0, pcModel + 64'd4);  // fence retires as a no-op
    endtask

    task automatic mulDivOps();
        xlenWord_t a;
        xlenWord_t b;
        a = randBits(64);
        b = randBits(64);
        loadConst(5'd1, a);
        loadConst(5'd2, b);
        loadConst(5'd3, 64'd0);
        loadConst(5'd4, 64'h8000_0000_0000_0000);
        loadConst(5'd5, '1);
        loadConst(5'd6, 64'h0000_0000_8000_0000);
        mdOp(3'b000, OP_OP, 5'd1, 5'd2, a * b);
        mdOp(3'b100, OP_OP, 5'd1, 5'd2, $signed(a) / $signed(b));
        mdOp(3'b101, OP_OP, 5'd1, 5'd2, a / b);
        mdOp(3'b110, OP_OP, 5'd1, 5'd2, $signed(a) % $signed(b));
        mdOp(3'b111, OP_OP, 5'd1, 5'd2, a % b);
        mdOp(3'b000, OP_OP32, 5'd1, 5'd2, wordExt(a[31:0] * b[31:0]));
        mdOp(3'b100, OP_OP32, 5'd1, 5'd2, wordExt($signed(a[31:0]) / $signed(b[31:0])));
        mdOp(3'b101, OP_OP32, 5'd1, 5'd2, wordExt(a[31:0] / b[31:0]));
        mdOp(3'b110, OP_OP32, 5'd1, 5'd2, wordExt($signed(a[31:0]) % $signed(b[31:0])));
        mdOp(3'b111, OP_OP32, 5'd1, 5'd2, wordExt(a[31:0] % b[31:0]));
        mdOp(3'b100, OP_OP, 5'd1, 5'd3, '1);  // divide by zero
        mdOp(3'b101, OP_OP, 5'd1, 5'd3, '1);
        mdOp(3'b110, OP_OP, 5'd1, 5'd3, a);
        mdOp(3'b111, OP_OP, 5'd1, 5'd3, a);
        mdOp(3'b100, OP_OP32, 5'd1, 5'd3, '1);
        mdOp(3'b101, OP_OP32, 5'd1, 5'd3, '1);
        mdOp(3'b110, OP_OP32, 5'd1, 5'd3, wordExt(a[31:0]));
        mdOp(3'b111, OP_OP32, 5'd1, 5'd3, wordExt(a[31:0]));
        mdOp(3'b100, OP_OP, 5'd4, 5'd5, 64'h8000_0000_0000_0000);  // most negative / -1
        mdOp(3'b110, OP_OP, 5'd4, 5'd5, 64'd0);
        mdOp(3'b100, OP_OP32, 5'd6, 5'd5, 64'hffff_ffff_8000_0000);
        mdOp(3'b110, OP_OP32, 5'd6, 5'd5, 64'd0);
    endtask

    task automatic storeLane(input int size, input int lane, input regAddr_t src);
        retire(sType(12'(lane), src, 5'd20, 3'(size)), 1'b0, '0, pcModel + 64'd4);
        for (int i = 0; i < (1 << size); i++) begin
            memModel[lane + i] = regModel[src][i*8 +: 8];
        end
    endtask

    task automatic loadLane(input int size, input logic zeroExt, input int lane);
        xlenWord_t expData;
        int        nBits;
        nBits = 8 << size;
        expData = '0;
        for (int i = 0; i < (1 << size); i++) begin
            expData[i*8 +: 8] = memModel[lane + i];
        end
        for (int i = nBits; i < 64; i++) begin
            expData[i] = expData[nBits-1] & ~zeroExt;
        end
        writeOp(iType(12'(lane), 5'd20, {zeroExt, 2'(size)}, 5'd11, OP_LOAD), expData);
    endtask

    task automatic memoryAccesses();
        loadConst(5'd20, DATA_ADDR);
        for (int sz = 3; sz >= 0; sz--) begin  // sd first, so every byte is known
            loadConst(5'd1, randBits(64));
            loadConst(5'd2, randBits(64));
            // top lane first, so a store that spills upward hits a lane already written
            for (int lane = 8 - (1 << sz); lane >= 0; lane -= (1 << sz)) begin
                storeLane(sz, lane, ((lane >> sz) % 2 == 1) ? 5'd1 : 5'd2);
            end
            for (int ls = 0; ls < 4; ls++) begin
                for (int lane = 0; lane < 8; lane += (1 << ls)) begin
                    loadLane(ls, 1'b0, lane);
                    if (ls < 3) begin
                        loadLane(ls, 1'b1, lane);
                    end
                end
            end
        end
    endtask

    task automatic branchOnce(input funct3_t f3, input regAddr_t r1, input regAddr_t r2);
        logic [12:0] off;
        xlenWord_t   x;
        xlenWord_t   y;
        logic        taken;
        off = {11'(randBits(11)), 2'b00};
        x = regModel[r1];
        y = regModel[r2];
        case (f3)
            3'b000:  taken = (x == y);
            3'b001:  taken = (x != y);
            3'b100:  taken = $signed(x) < $signed(y);
            3'b101:  taken = $signed(x) >= $signed(y);
            3'b110:  taken = x < y;
            default: taken = x >= y;
        endcase
        retire(bType(off, r2, r1, f3), 1'b0, '0,
               taken ? pcModel + {{51{off[12]}}, off} : pcModel + 64'd4);
    endtask

    task automatic branchesAndJumps();
        logic [20:0] joff;
        logic [11:0] jimm;
        loadConst(5'd1, randBits(64));
        loadConst(5'd2, randBits(64));
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                branchOnce(3'(f), 5'd1, 5'd2);
                branchOnce(3'(f), 5'd2, 5'd1);
                branchOnce(3'(f), 5'd1, 5'd1);
            end
        end
        joff = {19'(randBits(19)), 2'b00};
        retire(jType(joff, 5'd1), 1'b1, pcModel + 64'd4, pcModel + {{43{joff[20]}}, joff});
        jimm = {10'(randBits(10)), 2'b01};  // bit 0 must be dropped
        retire(iType(jimm, 5'd1, 3'b000, 5'd5, OP_JALR), 1'b1, pcModel + 64'd4,
               (regModel[1] + {{52{jimm[11]}}, jimm}) & ~64'd1);
    endtask

    initial begin
        inst = '0;
        instValid = 1'b0;
        reset = 1'b1;
        lfsrState = 16'd12;
        pcModel = RESET_PC;
        for (int i = 0; i < 32; i++) begin
            regModel[i] = '0;
        end
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;
        waitForResetPc();
        idleCycles();
        integerOps();
        mulDivOps();
        memoryAccesses();
        branchesAndJumps();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- rv64exec.f
common/rvIsaPkg.sv
common/rvMemPkg.sv
decode/immDecode.sv
execute/execUnit.sv
execute/nextPcUnit.sv
logic/regFile.sv
logic/dataMemory.sv
logic/rvCore.sv
testbench/rvCoreTb.sv

//--- Bender.yml
package:
  name: rv64exec

sources:
  - common/rvIsaPkg.sv
  - common/rvMemPkg.sv
  - decode/immDecode.sv
  - execute/execUnit.sv
  - execute/nextPcUnit.sv
  - logic/regFile.sv
  - logic/dataMemory.sv
  - logic/rvCore.sv
  - target: test
    files:
      - testbench/rvCoreTb.sv
